//--- mem_demo_pkg.sv
/* shared widths, sizes and encodings for the SRAM / register file demo
   imported by every design module that needs a type or a size */
package mem_demo_pkg;

   // fixed demo sizes
   localparam int SRAM_DEPTH  = 256;        // SRAM words
   localparam int FR_DEPTH    = 32;         // register file words
   localparam int INIT_WORDS  = 128;        // words filled by the init phase
   localparam int BLOCK_WORDS = 32;         // one SRAM block copied into the register file
   localparam int HALF_BLOCK  = 16;         // words copied back per write-back
   localparam int WB_BASE     = 128;        // first write-back SRAM address
   localparam logic [3:0] BLANK_DIGIT = 4'hF;  // digit value when nothing is shown

   typedef logic [31:0] data_t;       // data bus word
   typedef logic [7:0]  sram_addr_t;  // SRAM word address
   typedef logic [4:0]  fr_addr_t;    // register file address
   typedef logic [3:0]  view_t;       // view offset from the switches
   typedef logic [1:0]  block_t;      // block number
   typedef logic [9:0]  led_t;        // LED vector
   typedef logic [6:0]  seg_t;        // seven segments, active low, bit 0 = a
   typedef logic [3:0]  nibble_t;     // one hex digit

   // who drives the bus and who listens
   typedef enum logic [3:0] {
      BUS_IDLE       = 4'b0000,  // nobody
      DATA_TO_SRAM   = 4'b0001,  // sequencer data into SRAM
      DATA_FROM_SRAM = 4'b0010,  // SRAM word to the display
      SRAM_TO_FR     = 4'b0110,  // SRAM read, register file write
      DATA_FROM_FR   = 4'b1000,  // register file word to the display
      FR_TO_SRAM     = 4'b1001   // register file read, SRAM write
   } bus_op_t;

   // sequencer phases
   typedef enum logic [3:0] {
      PH_IDLE,       // idle view, waits for the init request
      PH_INIT,       // fill SRAM 0..127
      PH_INIT_DONE,  // bus idle, waits for the transfer request
      PH_XFER_RD,    // present SRAM and register file addresses
      PH_XFER_WR,    // SRAM read cycle
      PH_XFER_DONE,  // register file view
      PH_WB_SETUP,   // one spare cycle before write-back
      PH_WB,         // register file words to upper SRAM
      PH_WB_DONE     // ack high until the host drops req
   } phase_t;

endpackage

//--- mem_bus_if.sv
/* bus commands from the sequencer to the bus decoder and the two memories
   seq side drives everything, ctl side only listens */
`timescale 1ns/1ps

interface mem_bus_if import mem_demo_pkg::*; ();

   bus_op_t    op;         // current bus operation
   sram_addr_t sram_addr;  // SRAM word address
   fr_addr_t   fr_addr0;   // register file read port 0, also the write address
   fr_addr_t   fr_addr1;   // register file read port 1
   logic       fr_sel;     // 0 = port 0 on the output, 1 = port 1
   data_t      wdata;      // sequencer data for DATA_TO_SRAM

   modport seq (
      output op,
      output sram_addr,
      output fr_addr0,
      output fr_addr1,
      output fr_sel,
      output wdata
   );

   modport ctl (
      input op,
      input sram_addr,
      input fr_addr0,
      input fr_addr1,
      input fr_sel,
      input wdata
   );

endinterface

//--- register_file.sv
/* 32 x 32 register file, one synchronous write port at addr0 and two
   combinational read ports, rd_sel picks which one reaches rdata */
`timescale 1ns/1ps

module register_file import mem_demo_pkg::*; (
   input  logic     clk,
   input  logic     rst,     // sync, active low, clears every word
   input  logic     we,      // write enable
   input  logic     rd_sel,  // read port select
   input  fr_addr_t addr0,   // read port 0 and write address
   input  fr_addr_t addr1,   // read port 1
   input  data_t    wdata,
   output data_t    rdata
);

   data_t regs [FR_DEPTH];  // register array
   data_t rd0;              // port 0 word
   data_t rd1;              // port 1 word

   // clear has priority over a write
   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < FR_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[addr0] <= wdata;
      end
   end

   // both ports read in the same cycle
   assign rd0 = regs[addr0];
   assign rd1 = regs[addr1];

   // output mux
   always_comb begin
      if (rd_sel) begin
         rdata = rd1;
      end else begin
         rdata = rd0;
      end
   end

endmodule

//--- sram.sv
/* 256 x 32 single-port synchronous SRAM with active-low chip select and
   output enable; a read word appears one cycle after the address */
`timescale 1ns/1ps

module sram import mem_demo_pkg::*; (
   input  logic       clk,
   input  logic       cs_n,   // chip select, active low
   input  logic       oe_n,   // output enable, active low
   input  logic       wr,     // 1 = write, 0 = read
   input  sram_addr_t addr,
   input  data_t      wdata,
   output data_t      rdata   // registered read word
);

   data_t mem [SRAM_DEPTH];  // storage, contents survive reset

   always_ff @(posedge clk) begin
      if (!cs_n) begin
         if (wr) begin
            mem[addr] <= wdata;  // write cycle
         end else if (!oe_n) begin
            rdata <= mem[addr];  // read cycle, one cycle latency
         end
      end
   end

endmodule

//--- bus_control.sv
/* turns the bus operation into SRAM and register file enables, picks the
   data bus source and gates the LED and digit outputs */
`timescale 1ns/1ps

module bus_control import mem_demo_pkg::*; (
   mem_bus_if.ctl  bus,
   input  data_t   sram_rdata,
   input  data_t   fr_rdata,
   output logic    sram_cs_n,
   output logic    sram_oe_n,
   output logic    sram_wr,
   output logic    fr_we,
   output data_t   bus_data,
   output led_t    leds,
   output nibble_t digit0,
   output nibble_t digit1
);

   logic show;  // a display operation is on the bus

   always_comb begin
      sram_cs_n = 1'b1;  // everything off unless the op says so
      sram_oe_n = 1'b1;
      sram_wr   = 1'b0;
      fr_we     = 1'b0;
      bus_data  = '0;
      case (bus.op)
         DATA_TO_SRAM: begin
            sram_cs_n = 1'b0;
            sram_wr   = 1'b1;
            bus_data  = bus.wdata;  // sequencer drives
         end
         FR_TO_SRAM: begin
            sram_cs_n = 1'b0;
            sram_wr   = 1'b1;
            bus_data  = fr_rdata;
         end
         SRAM_TO_FR: begin
            sram_cs_n = 1'b0;
            sram_oe_n = 1'b0;
            fr_we     = 1'b1;       // register file takes the SRAM word
            bus_data  = sram_rdata;
         end
         DATA_FROM_SRAM: begin
            sram_cs_n = 1'b0;
            sram_oe_n = 1'b0;
            bus_data  = sram_rdata;
         end
         DATA_FROM_FR: bus_data = fr_rdata;  // read ports are combinational
         default: bus_data = '0;
      endcase
   end

   // display only on the two read-out ops
   assign show   = (bus.op == DATA_FROM_FR) || (bus.op == DATA_FROM_SRAM);
   assign leds   = show ? bus_data[9:0] : '0;
   assign digit0 = show ? bus_data[3:0] : BLANK_DIGIT;
   assign digit1 = show ? bus_data[7:4] : BLANK_DIGIT;

endmodule

//--- hex_encoder.sv
/* hex digit to active-low seven-segment pattern, bit 0 is segment a */
`timescale 1ns/1ps

module hex_encoder import mem_demo_pkg::*; (
   input  nibble_t digit,
   output seg_t    seg
);

   always_comb begin
      case (digit)       // gfedcba
         4'h0: seg = 7'b1000000;
         4'h1: seg = 7'b1111001;
         4'h2: seg = 7'b0100100;
         4'h3: seg = 7'b0110000;
         4'h4: seg = 7'b0011001;
         4'h5: seg = 7'b0010010;
         4'h6: seg = 7'b0000010;
         4'h7: seg = 7'b1111000;
         4'h8: seg = 7'b0000000;
         4'h9: seg = 7'b0010000;
         4'hA: seg = 7'b0001000;
         4'hB: seg = 7'b0000011;  // lower case b
         4'hC: seg = 7'b1000110;
         4'hD: seg = 7'b0100001;  // lower case d
         4'hE: seg = 7'b0000110;
         default: seg = 7'b0001110;  // F
      endcase
   end

endmodule

//--- demo_sequencer.sv
/* phase FSM of the demo: init, block transfer, register view, write-back and
   idle view, each phase started by a four-phase step_req/step_ack exchange */
`timescale 1ns/1ps

module demo_sequencer import mem_demo_pkg::*; (
   input  logic   clk,
   input  logic   rst,        // sync, active low
   input  logic   step_req,   // host request for the next phase
   input  block_t block_sel,  // block to transfer, also idle view block
   input  view_t  view_addr,  // view offset
   input  logic   read_sel,   // register view port select
   output logic   step_ack,
   mem_bus_if.seq bus
);

   phase_t     state;
   sram_addr_t cnt;       // word counter, shared by all copy phases
   block_t     blk;       // block latched at transfer start
   logic       wb_valid;  // a write-back has happened, idle view has data
   logic       start;     // new request
   logic       release_ack;

   assign start       = step_req && !step_ack;
   assign release_ack = step_req == 1'b0 && step_ack;

   // write-back reads the half picked by the latched block
   assign bus.fr_sel = (state == PH_WB_SETUP || state == PH_WB || state == PH_WB_DONE) ?
                       blk[0] : read_sel;

   always_ff @(posedge clk) begin
      if (!rst) begin
         state         <= PH_IDLE;
         cnt           <= '0;
         blk           <= '0;
         wb_valid      <= 1'b0;
         step_ack      <= 1'b0;
         bus.op        <= BUS_IDLE;
         bus.sram_addr <= '0;
         bus.fr_addr0  <= '0;
         bus.fr_addr1  <= '0;
         bus.wdata     <= '0;
      end else begin
         case (state)
            PH_IDLE: begin
               if (wb_valid) begin
                  // idle view, SRAM word shows up one cycle after the address
                  bus.op        <= DATA_FROM_SRAM;
                  bus.sram_addr <= sram_addr_t'(WB_BASE + HALF_BLOCK * block_sel + view_addr);
               end else begin
                  bus.op <= BUS_IDLE;  // nothing written back yet
               end
               if (start) begin
                  cnt   <= '0;
                  state <= PH_INIT;
               end
            end
            PH_INIT: begin
               // address i gets the 7-bit complement of i
               bus.op        <= DATA_TO_SRAM;
               bus.sram_addr <= cnt;
               bus.wdata     <= {25'd0, ~cnt[6:0]};
               cnt           <= cnt + 1'b1;
               if (cnt == sram_addr_t'(INIT_WORDS - 1)) begin
                  step_ack <= 1'b1;  // last write lands on the next edge
                  state    <= PH_INIT_DONE;
               end
            end
            PH_INIT_DONE: begin
               bus.op <= BUS_IDLE;
               if (release_ack) begin
                  step_ack <= 1'b0;
               end else if (start) begin
                  blk   <= block_sel;  // sampled once per transfer
                  cnt   <= '0;
                  state <= PH_XFER_RD;
               end
            end
            PH_XFER_RD: begin
               // the word read last round is written into the register file on this edge
               bus.op        <= SRAM_TO_FR;
               bus.sram_addr <= sram_addr_t'(BLOCK_WORDS * blk + cnt);
               bus.fr_addr0  <= fr_addr_t'(cnt);
               state         <= PH_XFER_WR;
            end
            PH_XFER_WR: begin
               cnt <= cnt + 1'b1;  // SRAM registers the word here
               if (cnt == sram_addr_t'(BLOCK_WORDS - 1)) begin
                  step_ack <= 1'b1;
                  state    <= PH_XFER_DONE;
               end else begin
                  state <= PH_XFER_RD;
               end
            end
            PH_XFER_DONE: begin
               // register view, first edge here still completes word 31
               bus.op       <= DATA_FROM_FR;
               bus.fr_addr0 <= fr_addr_t'(view_addr);
               bus.fr_addr1 <= fr_addr_t'(view_addr) + fr_addr_t'(HALF_BLOCK);
               if (release_ack) begin
                  step_ack <= 1'b0;
               end else if (start) begin
                  cnt   <= '0;
                  state <= PH_WB_SETUP;
               end
            end
            PH_WB_SETUP: begin
               bus.op <= BUS_IDLE;  // lets fr_sel settle to the block half
               state  <= PH_WB;
            end
            PH_WB: begin
               bus.op        <= FR_TO_SRAM;
               bus.sram_addr <= sram_addr_t'(WB_BASE + HALF_BLOCK * blk + cnt);
               bus.fr_addr0  <= fr_addr_t'(cnt);
               bus.fr_addr1  <= fr_addr_t'(cnt) + fr_addr_t'(HALF_BLOCK);
               cnt           <= cnt + 1'b1;
               if (cnt == sram_addr_t'(HALF_BLOCK - 1)) begin
                  step_ack <= 1'b1;
                  state    <= PH_WB_DONE;
               end
            end
            PH_WB_DONE: begin
               bus.op <= BUS_IDLE;  // last SRAM write is on the edge entering here+1
               if (!step_req) begin
                  step_ack <= 1'b0;
                  wb_valid <= 1'b1;
                  state    <= PH_IDLE;
               end
            end
            default: state <= PH_IDLE;
         endcase
      end
   end

endmodule

//--- fr_sram_demo.sv
/* top level of the SRAM / register file demo, sequencer, bus decoder, both
   memories and two hex digits on one shared data path */
`timescale 1ns/1ps

module fr_sram_demo import mem_demo_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   step_req,
   input  block_t block_sel,
   input  view_t  view_addr,
   input  logic   read_sel,
   output logic   step_ack,
   output led_t   leds,
   output seg_t   hex0,
   output seg_t   hex1
);

   mem_bus_if u_bus ();

   data_t   sram_rdata, fr_rdata, bus_data;
   logic    sram_cs_n, sram_oe_n, sram_wr, fr_we;
   nibble_t digit0, digit1;

   demo_sequencer u_seq (
      .clk(clk), .rst(rst), .step_req(step_req), .block_sel(block_sel),
      .view_addr(view_addr), .read_sel(read_sel), .step_ack(step_ack), .bus(u_bus.seq)
   );

   bus_control u_ctl (
      .bus(u_bus.ctl), .sram_rdata(sram_rdata), .fr_rdata(fr_rdata),
      .sram_cs_n(sram_cs_n), .sram_oe_n(sram_oe_n), .sram_wr(sram_wr), .fr_we(fr_we),
      .bus_data(bus_data), .leds(leds), .digit0(digit0), .digit1(digit1)
   );

   sram u_sram (
      .clk(clk), .cs_n(sram_cs_n), .oe_n(sram_oe_n), .wr(sram_wr),
      .addr(u_bus.sram_addr), .wdata(bus_data), .rdata(sram_rdata)
   );

   register_file u_fr (
      .clk(clk), .rst(rst), .we(fr_we), .rd_sel(u_bus.fr_sel), .addr0(u_bus.fr_addr0),
      .addr1(u_bus.fr_addr1), .wdata(bus_data), .rdata(fr_rdata)
   );

   hex_encoder u_hex0 (.digit(digit0), .seg(hex0));  // low nibble
   hex_encoder u_hex1 (.digit(digit1), .seg(hex1));

endmodule

//--- fr_sram_demo_tb.sv
/* testbench for the SRAM / register file demo, replays demo_cases.txt as
   step handshakes and view changes and checks ack, LEDs and both digits */
`timescale 1ns/1ps

module fr_sram_demo_tb import mem_demo_pkg::*; ();

   localparam int CYCLES_PER_CASE = 400;  // longest phase is init, about 145 cycles
   // active-low patterns for 0..F, bit 0 is segment a
   localparam seg_t SEG_TABLE [16] = '{
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
   };

   logic   clk = 1'b0;
   logic   rst;
   logic   step_req;
   block_t block_sel;
   view_t  view_addr;
   logic   read_sel;
   logic   step_ack;
   led_t   leds;
   seg_t   hex0;
   seg_t   hex1;

   logic [63:0] case_op [$];  // op word as read, "step" or "view"
   block_t      case_blk [$];
   view_t       case_view [$];
   logic        case_sel [$];
   led_t        case_leds [$];

   int cycles = 0;
   int cycle_limit = 0;  // 0 until the cases are loaded
   int steps = 0;        // handshakes done so far
   int checks = 0;
   int led_errs = 0;
   int seg_errs = 0;
   int ack_errs = 0;
   int other_errs = 0;

   fr_sram_demo u_dut (
      .clk(clk), .rst(rst), .step_req(step_req), .block_sel(block_sel),
      .view_addr(view_addr), .read_sel(read_sel), .step_ack(step_ack),
      .leds(leds), .hex0(hex0), .hex1(hex1)
   );

   always #50 clk = ~clk;  // 100 ns period

   // run limit, guards every wait loop below
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run still busy after %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic check_leds(led_t got, led_t exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED %0t ns: %s leds %h, expected %h", $time, what, got, exp);
         led_errs++;
      end
   endtask

   task automatic check_seg(seg_t got, seg_t exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED %0t ns: %s segments %b, expected %b", $time, what, got, exp);
         seg_errs++;
      end
   endtask

   task automatic check_ack(logic got, logic exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED %0t ns: %s step_ack %b, expected %b", $time, what, got, exp);
         ack_errs++;
      end
   endtask

   // blank after reset and after each init, shown in register and idle views
   function automatic bit display_on(int done_steps);
      return done_steps != 0 && done_steps % 3 != 1;
   endfunction

   task automatic check_display(led_t exp, bit shown, string what);
      seg_t exp0;
      seg_t exp1;
      exp0 = shown ? SEG_TABLE[exp[3:0]] : SEG_TABLE[BLANK_DIGIT];
      exp1 = shown ? SEG_TABLE[exp[7:4]] : SEG_TABLE[BLANK_DIGIT];
      check_leds(leds, exp, what);
      check_seg(hex0, exp0, {what, " hex0"});
      check_seg(hex1, exp1, {what, " hex1"});
   endtask

   task automatic set_inputs(block_t b, view_t v, logic s);
      @(posedge clk);
      #5;
      block_sel = b;
      view_addr = v;
      read_sel  = s;
   endtask

   // one four-phase exchange, host idles a few random cycles first
   task automatic run_step();
      int idle;
      idle = int'($urandom % 4);
      repeat (idle) @(posedge clk);
      @(posedge clk);
      #5 step_req = 1'b1;
      @(negedge clk);
      check_ack(step_ack, 1'b0, "phase just started");
      while (step_ack !== 1'b1) @(negedge clk);  // phase runs
      repeat (3) begin
         @(negedge clk);
         check_ack(step_ack, 1'b1, "req still held");
      end
      @(posedge clk);
      #5 step_req = 1'b0;
      @(posedge clk);  // first edge that sees req low
      @(negedge clk);
      check_ack(step_ack, 1'b0, "cycle after req dropped");
      steps++;
   endtask

   task automatic load_cases(output bit ok);
      int          fd;
      int          n;
      string       line;
      logic [63:0] op_word;
      int          b, v, s, e;
      ok = 1'b0;
      fd = $fopen("demo_cases.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") begin
               continue;  // column notes
            end
            n = $sscanf(line, "%s %d %d %d %h", op_word, b, v, s, e);
            if (n == 5 && (op_word == "step" || op_word == "view")) begin
               case_op.push_back(op_word);
               case_blk.push_back(block_t'(b));
               case_view.push_back(view_t'(v));
               case_sel.push_back(s[0]);
               case_leds.push_back(led_t'(e));
            end else if (n > 0) begin
               $display("cases file line could not be read: %s", line);
               other_errs++;
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      bit loaded;
      int errors;
      rst       = 1'b0;  // reset held from time 0
      step_req  = 1'b0;
      block_sel = '0;
      view_addr = '0;
      read_sel  = 1'b0;
      void'($urandom(19702));
      load_cases(loaded);
      cycle_limit = case_op.size() * CYCLES_PER_CASE + 1000;
      repeat (16) @(posedge clk);
      #5 rst = 1'b1;
      if (!loaded) begin
         $display("cases file demo_cases.txt could not be opened");
         other_errs++;
      end else begin
         @(negedge clk);
         check_ack(step_ack, 1'b0, "after reset");
         check_display('0, 1'b0, "after reset");
         for (int i = 0; i < case_op.size(); i++) begin
            set_inputs(case_blk[i], case_view[i], case_sel[i]);
            if (case_op[i] == "step") begin
               run_step();
            end
            repeat (4) @(posedge clk);  // views settle within 3 cycles
            @(negedge clk);
            check_display(case_leds[i], display_on(steps), $sformatf("case %0d", i + 1));
         end
      end
      errors = led_errs + seg_errs + ack_errs + other_errs;
      $display("checks %0d, errors %0d: leds %0d, segments %0d, ack %0d, other %0d",
               checks, errors, led_errs, seg_errs, ack_errs, other_errs);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- demo_cases.txt
# op block view sel leds(hex), one case per line
# step runs one handshake first, leds is the value 4 cycles after the inputs settle
view 0 0 0 000
step 1 0 0 000
step 1 0 0 05f
view 1 5 0 05a
view 1 5 1 04a
view 1 15 1 040
view 1 9 0 056
view 1 5 0 05a
step 1 3 0 04c
view 1 0 0 04f
view 1 15 0 040
view 1 7 1 048
step 2 0 0 000
step 2 4 0 03b
view 2 4 1 02b
view 2 12 0 033
view 2 12 1 023
view 2 4 0 03b
step 2 0 0 03f
view 2 10 0 035
view 2 15 1 030
view 1 3 0 04c

//--- fr_sram_demo.f
mem_demo_pkg.sv
mem_bus_if.sv
register_file.sv
sram.sv
bus_control.sv
hex_encoder.sv
demo_sequencer.sv
fr_sram_demo.sv
fr_sram_demo_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the SRAM / register file demo testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fr_sram_demo_tb \
   -f fr_sram_demo.f -o fr_sram_demo_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/fr_sram_demo_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
